// File: rtl/sd_dma_consts.svh
`ifndef SD_DMA_CONSTS_SVH
`define SD_DMA_CONSTS_SVH

// ----------------------------------------------------------------------------
// transfer geometry
// ----------------------------------------------------------------------------

// one card sector per block
`define BLOCK_BYTES 512

// host side address, full 64K space
`define ADDR_W 16

// ----------------------------------------------------------------------------
// buffer and link sizing
// ----------------------------------------------------------------------------

// 4 KB buffer, host addresses wrap onto it
`define RAM_ABITS 12

// system clocks per sclk half period
`define SPI_DIV 4

`endif

// File: rtl/dma_cmd_pkg.sv
package dma_cmd_pkg;

	// ------------------------------------------------------------------------
	// host command nibble
	// ------------------------------------------------------------------------

	// field view of the nibble, bit 3 is the direction
	typedef struct packed
	{
		logic       to_spi;    // 1: buffer ram -> card ("write")
		logic [2:0] nblocks;   // 512-byte blocks to move
	} dma_cmd_fields_t;

	// same four bits seen whole (start test) or split (latching)
	typedef union packed
	{
		logic [3:0]      raw;      // nonzero starts a transfer
		dma_cmd_fields_t fields;
	} dma_cmd_t;

	// ------------------------------------------------------------------------
	// block transfer FSM
	// ------------------------------------------------------------------------

	typedef enum logic [2:0]
	{
		IDLE,       // bus belongs to the host
		NBYTE,      // launch next spi byte
		WAIT_RAM,   // let registered ram data settle before tx latch
		BUSY,       // byte on the wire, wait for dsr
		BLOCK,      // block boundary, next block or finish
		OVER        // hand the bus back
	} dma_state_e;

endpackage

// File: rtl/dma_bus_pkg.sv
`include "sd_dma_consts.svh"

package dma_bus_pkg;

	// ------------------------------------------------------------------------
	// buffer ram port, one request per cycle
	// ------------------------------------------------------------------------

	typedef struct packed
	{
		logic [`ADDR_W-1:0] addr;    // low bits index the buffer
		logic [7:0]         wdata;
		logic               we;      // write strobe, active high
	} ram_req_t;

	// ------------------------------------------------------------------------
	// spi byte port
	// ------------------------------------------------------------------------

	// dma -> spi master
	typedef struct packed
	{
		logic       start;   // one-cycle strobe
		logic [7:0] tx;      // byte to shift out
	} spi_req_t;

	// spi master -> dma
	typedef struct packed
	{
		logic       dsr;     // data ready, one-cycle pulse
		logic [7:0] rx;      // valid together with dsr
	} spi_rsp_t;

endpackage

// File: rtl/buffer_ram.sv
`timescale 1ns/1ns
`include "sd_dma_consts.svh"

module buffer_ram
(
	input  logic                  clk,
	input  dma_bus_pkg::ram_req_t req,
	output logic [7:0]            rdata
);
	logic [7:0]            mem [0:(1 << `RAM_ABITS) - 1];
	logic [`RAM_ABITS-1:0] idx;

	// upper address bits ignored, buffer repeats through the host space
	assign idx = req.addr[`RAM_ABITS-1:0];

	// ------------------------------------------------------------------------
	// single port, write first into the array, read registered
	// ------------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (req.we)
			mem[idx] <= req.wdata;
		rdata <= mem[idx];            // old data on a write cycle
	end

endmodule

// File: rtl/spi_byte_master.sv
`timescale 1ns/1ns
`include "sd_dma_consts.svh"

module spi_byte_master
(
	input  logic                  clk,
	input  logic                  reset_n,
	input  dma_bus_pkg::spi_req_t spi_req,
	input  logic                  miso,
	output dma_bus_pkg::spi_rsp_t spi_rsp,
	output logic                  sclk,
	output logic                  mosi
);
	localparam int DIV_W = $clog2(`SPI_DIV);

	logic             active;      // byte in flight
	logic [DIV_W-1:0] div;         // half period divider
	logic [3:0]       edge_cnt;    // sclk edges so far, 16 per byte
	logic [7:0]       tx_sh;
	logic [7:0]       rx_sh;
	logic             tick;        // sclk toggles this cycle

	assign tick = active && (div == DIV_W'(`SPI_DIV - 1));
	assign mosi = tx_sh[7];        // msb first

	// ------------------------------------------------------------------------
	// mode 0: sclk idles low, sample on rise, shift on fall
	// ------------------------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			active      <= 1'b0;
			sclk        <= 1'b0;
			spi_rsp.dsr <= 1'b0;
		end
		else
		begin
			spi_rsp.dsr <= 1'b0;
			if (spi_req.start && !active)
			begin
				active   <= 1'b1;
				tx_sh    <= spi_req.tx;
				edge_cnt <= '0;
				// first half period one short, dsr lands 16*SPI_DIV after start
				div      <= DIV_W'(1);
			end
			else if (active)
			begin
				div <= tick ? '0 : div + 1'b1;
				if (tick)
				begin
					sclk     <= ~sclk;
					edge_cnt <= edge_cnt + 1'b1;
					if (!sclk)
						rx_sh <= {rx_sh[6:0], miso};   // rising edge
					else
						tx_sh <= {tx_sh[6:0], 1'b1};   // falling edge, next bit out

					if (edge_cnt == 4'd15)             // last fall, sclk back low
					begin
						active      <= 1'b0;
						spi_rsp.dsr <= 1'b1;
						spi_rsp.rx  <= rx_sh;
					end
				end
			end
		end
	end

endmodule

// File: rtl/dma_rw.sv
`timescale 1ns/1ns
`include "sd_dma_consts.svh"

module dma_rw
(
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  cmd_valid,
	input  dma_cmd_pkg::dma_cmd_t cmd,
	input  logic [`ADDR_W-1:0]    cmd_addr,
	input  logic [7:0]            ram_rdata,
	input  dma_bus_pkg::spi_rsp_t spi_rsp,
	output logic                  ready,
	output dma_bus_pkg::ram_req_t dma_ram,
	output dma_bus_pkg::spi_req_t spi_req,
	output logic                  cs_n
);
	import dma_cmd_pkg::*;

	localparam int CNT_W = $clog2(`BLOCK_BYTES);

	dma_state_e       state;
	logic             busy;        // transfer in progress, dma owns the bus
	logic             to_spi;      // latched direction
	logic [2:0]       rblocks;     // blocks left, including the current one
	logic [CNT_W-1:0] byte_cnt;    // byte within the block
	logic             last_byte;

	assign ready = ~busy;
	assign cs_n  = ~busy;          // card selected for the whole transfer

	assign last_byte = (byte_cnt == CNT_W'(`BLOCK_BYTES - 1));

	// ------------------------------------------------------------------------
	// block transfer FSM
	// ------------------------------------------------------------------------
	// addr always points at base+k, k counting across blocks
	// read:  each received byte is written at the current addr, then addr+1
	// write: addr is read ahead, tx is taken after one WAIT_RAM cycle

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			state         <= IDLE;
			busy          <= 1'b0;
			rblocks       <= '0;
			spi_req.start <= 1'b0;
			dma_ram.we    <= 1'b0;
		end
		else
		begin
			spi_req.start <= 1'b0;                    // strobes last one cycle
			dma_ram.we    <= 1'b0;
			if (dma_ram.we)
				dma_ram.addr <= dma_ram.addr + 1'b1;  // step past the byte just written

			case (state)
			IDLE:
			begin
				if (cmd_valid && cmd.raw != 4'h0)
				begin
					busy         <= 1'b1;
					to_spi       <= cmd.fields.to_spi;
					rblocks      <= cmd.fields.nblocks;
					byte_cnt     <= '0;
					dma_ram.addr <= cmd_addr;          // buffer base
					// write direction needs ram data before the first start
					state <= cmd.fields.to_spi ? WAIT_RAM : NBYTE;
				end
			end
			WAIT_RAM:
			begin
				state <= NBYTE;                        // rdata for addr valid next cycle
			end
			NBYTE:
			begin
				spi_req.tx    <= to_spi ? ram_rdata : 8'hFF;   // idle ones when reading
				spi_req.start <= 1'b1;
				state         <= BUSY;
			end
			BUSY:
			begin
				if (spi_rsp.dsr)
				begin
					byte_cnt <= byte_cnt + 1'b1;       // wraps to 0 at block end
					if (to_spi)
						dma_ram.addr <= dma_ram.addr + 1'b1;   // fetch next byte
					else
					begin
						dma_ram.we    <= 1'b1;         // store received byte
						dma_ram.wdata <= spi_rsp.rx;
					end

					if (last_byte)
						state <= BLOCK;
					else
						state <= to_spi ? WAIT_RAM : NBYTE;
				end
			end
			BLOCK:
			begin
				// nblocks of 0 with the direction bit set still moves one block
				if (rblocks > 3'd1)
				begin
					rblocks <= rblocks - 1'b1;
					state   <= to_spi ? WAIT_RAM : NBYTE;
				end
				else
					state <= OVER;
			end
			OVER:
			begin
				busy    <= 1'b0;                       // ready rises, host gets bus back
				rblocks <= '0;
				state   <= IDLE;
			end
			default:
				state <= IDLE;
			endcase
		end
	end

endmodule

// File: rtl/sd_dma_top.sv
`timescale 1ns/1ns
`include "sd_dma_consts.svh"

module sd_dma_top
(
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  cmd_valid,
	input  dma_cmd_pkg::dma_cmd_t cmd,
	input  logic [`ADDR_W-1:0]    cmd_addr,
	input  dma_bus_pkg::ram_req_t host_req,
	input  logic                  miso,
	output logic [7:0]            host_rdata,
	output logic                  ready,
	output logic                  sclk,
	output logic                  mosi,
	output logic                  cs_n
);
	import dma_bus_pkg::*;

	ram_req_t dma_ram;            // dma side of the buffer bus
	ram_req_t ram_req;            // what the buffer actually sees
	spi_req_t spi_req;
	spi_rsp_t spi_rsp;

	// dma owns the bus while busy, host requests dropped then
	assign ram_req = ready ? host_req : dma_ram;

	dma_rw u_dma_rw
	(
		.clk       (clk),
		.reset_n   (reset_n),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.cmd_addr  (cmd_addr),
		.ram_rdata (host_rdata),   // shared read data, one consumer at a time
		.spi_rsp   (spi_rsp),
		.ready     (ready),
		.dma_ram   (dma_ram),
		.spi_req   (spi_req),
		.cs_n      (cs_n)
	);

	spi_byte_master u_spi
	(
		.clk     (clk),
		.reset_n (reset_n),
		.spi_req (spi_req),
		.miso    (miso),
		.spi_rsp (spi_rsp),
		.sclk    (sclk),
		.mosi    (mosi)
	);

	buffer_ram u_ram
	(
		.clk   (clk),
		.req   (ram_req),
		.rdata (host_rdata)
	);

endmodule

// File: verification/spi_card_model.sv
`timescale 1ns/1ns

module spi_card_model
(
	input  logic clk,
	input  logic cs_n,
	input  logic sclk,
	input  logic mosi,
	output logic miso
);
	logic [7:0] tx_sh   = 8'hFF;
	logic [7:0] rx_sh   = 8'h00;
	logic [2:0] bit_cnt = 3'd0;
	logic       sclk_q  = 1'b0;
	logic       cs_q    = 1'b1;
	int         nbytes  = 0;         // bytes since cs_n fell
	logic [7:0] rx_mem [0:4095];     // mosi bytes in arrival order

	// card data for byte i of the current selection
	function automatic logic [7:0] pattern(int i);
		return 8'((i * 7 + 3) % 256);
	endfunction

	assign miso = tx_sh[7];          // msb first, mode 0

	// sampled mid-cycle on the falling system clock, sclk and mosi settled there
	always @(negedge clk)
	begin
		sclk_q <= sclk;
		cs_q   <= cs_n;
		if (cs_q && !cs_n)                         // new selection
		begin
			nbytes  <= 0;
			bit_cnt <= 3'd0;
			tx_sh   <= pattern(0);
		end
		else if (!cs_n && sclk && !sclk_q)         // rising sclk, take mosi
		begin
			rx_sh   <= {rx_sh[6:0], mosi};
			bit_cnt <= bit_cnt + 3'd1;             // wraps after bit 7
			if (bit_cnt == 3'd7)
			begin
				rx_mem[12'(nbytes)] <= {rx_sh[6:0], mosi};
				nbytes              <= nbytes + 1;
			end
		end
		else if (!cs_n && !sclk && sclk_q)         // falling sclk
		begin
			if (bit_cnt == 3'd0)
				tx_sh <= pattern(nbytes);          // nbytes already advanced
			else
				tx_sh <= {tx_sh[6:0], 1'b1};
		end
	end

endmodule

// File: verification/tb_sd_dma.sv
`timescale 1ns/1ns
`include "sd_dma_consts.svh"

module tb_sd_dma;
	import dma_cmd_pkg::*;
	import dma_bus_pkg::*;

	// ~6 blocks x 512 bytes x (16*SPI_DIV+4) cycles, roughly doubled
	localparam int MAX_CYCLES = 400000;
	localparam int RAM_BYTES  = 1 << `RAM_ABITS;

	logic               clk = 1'b0;
	logic               reset_n;
	logic               cmd_valid;
	dma_cmd_t           cmd;
	logic [`ADDR_W-1:0] cmd_addr;
	ram_req_t           host_req;
	logic               miso;
	logic [7:0]         host_rdata;
	logic               ready;
	logic               sclk;
	logic               mosi;
	logic               cs_n;
	int                 cycles      = 0;
	int                 checks      = 0;
	int                 errors      = 0;
	int                 errors_seen = 0;   // errors before the current test
	logic [7:0]         preload [0:`BLOCK_BYTES-1];

	always #50 clk = ~clk;                 // 100 ns period

	sd_dma_top DUT (.*);
	spi_card_model card (.*);

	// hard stop if a transfer never finishes
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES)
		begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------

	// byte i of a card read, (i*7+3) mod 256
	function automatic logic [7:0] card_byte(int i);
		return 8'((i * 7 + 3) % 256);
	endfunction

	task automatic check_eq(string name, logic [31:0] exp, logic [31:0] got);
		checks++;
		assert (got === exp)
		else
		begin
			$display("ERR %0t %s expected %0h got %0h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic report_test(string name);
		$display("%s: %0d errors", name, errors - errors_seen);
		errors_seen = errors;
	endtask

	task automatic host_write(logic [15:0] addr, logic [7:0] data);
		@(negedge clk);
		host_req.addr  = addr;
		host_req.wdata = data;
		host_req.we    = 1'b1;
		@(negedge clk);
		host_req.we    = 1'b0;
	endtask

	// registered read, data stable at the next falling edge
	task automatic expect_byte(logic [15:0] addr, logic [7:0] exp);
		@(negedge clk);
		host_req.addr = addr;
		host_req.we   = 1'b0;
		@(negedge clk);
		check_eq("host_rdata", 32'(exp), 32'(host_rdata));
	endtask

	task automatic send_cmd(logic [3:0] nibble, logic [15:0] addr);
		@(negedge clk);
		cmd_valid = 1'b1;
		cmd.raw   = nibble;
		cmd_addr  = addr;
		@(negedge clk);
		cmd_valid = 1'b0;
	endtask

	task automatic wait_ready();
		while (!ready)
			@(negedge clk);                    // bounded by the cycle counter
	endtask

	// ------------------------------------------------------------------------
	// tests
	// ------------------------------------------------------------------------

	task automatic test_reset();
		logic [15:0] addr;
		logic [7:0]  data;
		addr = 16'($urandom);
		data = 8'($urandom);
		check_eq("ready", 1, 32'(ready));
		check_eq("cs_n", 1, 32'(cs_n));
		check_eq("sclk", 0, 32'(sclk));
		host_write(addr, data);
		expect_byte(addr, data);
		report_test("reset and host access");
	endtask

	task automatic test_read(logic [2:0] nblocks, string name);
		logic [15:0] base;
		int          nbytes;
		base   = 16'($urandom);
		nbytes = int'(nblocks) * `BLOCK_BYTES;
		send_cmd({1'b0, nblocks}, base);
		check_eq("ready", 0, 32'(ready));      // dma holds the bus now
		wait_ready();
		check_eq("card byte count", 32'(nbytes), 32'(card.nbytes));
		for (int k = 0; k < nbytes; k++)
		begin
			expect_byte(16'((base + k) % RAM_BYTES), card_byte(k));
			check_eq("mosi byte", 32'hFF, 32'(card.rx_mem[12'(k)]));   // idle ones
		end
		report_test(name);
	endtask

	task automatic test_write();
		logic [15:0] base;
		base = 16'($urandom);
		for (int k = 0; k < `BLOCK_BYTES; k++)
		begin
			preload[9'(k)] = 8'($urandom);
			host_write(16'(base + k), preload[9'(k)]);
		end
		send_cmd(4'b1001, base);               // ram to card, one block
		check_eq("ready", 0, 32'(ready));
		wait_ready();
		check_eq("card byte count", `BLOCK_BYTES, 32'(card.nbytes));
		for (int k = 0; k < `BLOCK_BYTES; k++)
			check_eq("mosi byte", 32'(preload[9'(k)]), 32'(card.rx_mem[12'(k)]));
		report_test("single-block write");
	endtask

	task automatic test_ownership();
		logic [15:0] base;
		logic [15:0] outside;
		logic [7:0]  old;
		base    = 16'($urandom);
		outside = 16'(base + RAM_BYTES / 2);   // half a buffer away, clear of the block
		old     = 8'($urandom);
		send_cmd(4'h0, base);
		check_eq("ready", 1, 32'(ready));      // zero nibble starts nothing
		host_write(outside, old);
		send_cmd(4'b0001, base);
		host_write(outside, ~old);             // dropped, bus belongs to the dma
		send_cmd(4'b0011, outside);            // busy, must be ignored
		wait_ready();
		check_eq("card byte count", `BLOCK_BYTES, 32'(card.nbytes));
		expect_byte(outside, old);
		report_test("bus ownership");
	endtask

	initial
	begin
		reset_n   = 1'b0;
		cmd_valid = 1'b0;
		cmd       = '0;
		cmd_addr  = '0;
		host_req  = '0;
		void'($urandom(32'h2fc8));
		repeat (16) @(negedge clk);
		reset_n = 1'b1;

		test_reset();
		test_read(3'd1, "single-block read");
		test_read(3'd3, "three-block read");
		test_write();
		test_ownership();

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: tb.f
+incdir+rtl
rtl/dma_cmd_pkg.sv
rtl/dma_bus_pkg.sv
rtl/buffer_ram.sv
rtl/spi_byte_master.sv
rtl/dma_rw.sv
rtl/sd_dma_top.sv
verification/spi_card_model.sv
verification/tb_sd_dma.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then decide on the log contents
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_sd_dma -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log && exit 1 || exit 0
